/* logic/mem_system_pkg.sv */
/*
 * Memory subsystem package
 * Widths, address map, host request and response structs, boot ROM table
 */

package mem_system_pkg;

  // Bus widths
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned ByteOffWidth = $clog2(StrbWidth);

  localparam int unsigned NumCores = 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // L2 scratch memory, word interleaved across banks
  localparam int unsigned NumL2Banks      = 4;
  localparam int unsigned L2BankNumWords  = 64;
  localparam int unsigned L2BankSelWidth  = $clog2(NumL2Banks);
  localparam int unsigned L2BankAddrWidth = $clog2(L2BankNumWords);
  localparam addr_t       L2BaseAddr      = 32'h8000_0000;
  localparam addr_t       L2Size          = 32'd1024;

  // Boot ROM
  localparam int unsigned BootromNumWords  = 8;
  localparam int unsigned BootromAddrWidth = $clog2(BootromNumWords);
  localparam addr_t       BootromBaseAddr  = 32'hA000_0000;
  localparam addr_t       BootromSize      = BootromNumWords * StrbWidth; // 32 bytes

  // Control register block
  localparam addr_t       CtrlBaseAddr = 32'h4000_0000;
  localparam addr_t       CtrlSize     = 32'h0001_0000;
  localparam int unsigned CtrlOffWidth = $clog2(CtrlSize);

  localparam logic [CtrlOffWidth-1:0] EocOffset      = 'h0;
  localparam logic [CtrlOffWidth-1:0] WakeUpOffset   = 'h4;
  localparam logic [CtrlOffWidth-1:0] NumCoresOffset = 'h8;

  // Boot table, upper half is a tag and lower half the word index
  localparam data_t BootromContent [BootromNumWords] = '{
    32'hB007_0000,
    32'hB007_0001,
    32'hB007_0002,
    32'hB007_0003,
    32'hB007_0004,
    32'hB007_0005,
    32'hB007_0006,
    32'hB007_0007
  };

  // Host side request, one per cycle
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } sys_req_t;

  // Response, always one cycle after the request
  typedef struct packed {
    logic  rvalid;
    data_t rdata;
    logic  err;
  } sys_resp_t;

  // Crossbar targets
  typedef enum logic [1:0] {
    TgtL2,
    TgtBootrom,
    TgtCtrl,
    TgtNone
  } target_e;

endpackage : mem_system_pkg

/* logic/l2_bank.sv */
/*
 * L2 bank, single-port SRAM with byte enables
 */

`timescale 1ns/1ps

module l2_bank (
  input  logic                                       clk_i,
  input  logic                                       req_i,
  input  logic                                       we_i,
  input  logic [mem_system_pkg::L2BankAddrWidth-1:0] addr_i,
  input  mem_system_pkg::data_t                      wdata_i,
  input  mem_system_pkg::strb_t                      be_i,
  output mem_system_pkg::data_t                      rdata_o
);

  mem_system_pkg::data_t mem [mem_system_pkg::L2BankNumWords];

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < mem_system_pkg::StrbWidth; b++) begin
        if (be_i[b]) mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8]; // Strobed bytes only
      end
    end
  end

  // Registered read port
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule : l2_bank

/* logic/l2_mem.sv */
/*
 * L2 scratch memory
 * Consecutive words go to consecutive banks, read word returned one cycle later
 */

`timescale 1ns/1ps

module l2_mem (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mem_system_pkg::sys_req_t  req_i,
  output mem_system_pkg::sys_resp_t resp_o
);

  logic [mem_system_pkg::L2BankSelWidth-1:0]  bank_sel, bank_q;
  logic [mem_system_pkg::L2BankAddrWidth-1:0] row;
  logic [mem_system_pkg::NumL2Banks-1:0]      bank_req;
  mem_system_pkg::data_t [mem_system_pkg::NumL2Banks-1:0] bank_rdata;
  logic                                       valid_q, read_q;

  // Low word bits pick the bank, the bits above pick the row
  assign bank_sel = req_i.addr[mem_system_pkg::ByteOffWidth +: mem_system_pkg::L2BankSelWidth];
  assign row      = req_i.addr[mem_system_pkg::ByteOffWidth + mem_system_pkg::L2BankSelWidth +:
                               mem_system_pkg::L2BankAddrWidth];

  for (genvar i = 0; i < mem_system_pkg::NumL2Banks; i++) begin : gen_banks
    assign bank_req[i] = req_i.req && (bank_sel == i);

    l2_bank i_l2_bank (
      .clk_i  (clk_i        ),
      .req_i  (bank_req[i]  ),
      .we_i   (req_i.we     ),
      .addr_i (row          ),
      .wdata_i(req_i.wdata  ),
      .be_i   (req_i.strb   ),
      .rdata_o(bank_rdata[i])
    );
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      read_q  <= 1'b0;
      bank_q  <= '0;
    end else begin
      valid_q <= req_i.req;
      read_q  <= req_i.req && !req_i.we;
      if (req_i.req) bank_q <= bank_sel;
    end
  end

  // Writes answer with zero data
  always_comb begin
    resp_o        = '0;
    resp_o.rvalid = valid_q;
    resp_o.rdata  = read_q ? bank_rdata[bank_q] : '0;
  end

endmodule : l2_mem

/* logic/bootrom.sv */
/*
 * Boot ROM
 * Fixed boot table with a registered read, writes are answered and dropped
 */

`timescale 1ns/1ps

module bootrom (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mem_system_pkg::sys_req_t  req_i,
  output mem_system_pkg::sys_resp_t resp_o
);

  logic [mem_system_pkg::BootromAddrWidth-1:0] idx;
  mem_system_pkg::data_t                       rdata_q;
  logic                                        valid_q;

  assign idx = req_i.addr[mem_system_pkg::ByteOffWidth +: mem_system_pkg::BootromAddrWidth];

  always_ff @(posedge clk_i) begin
    if (reset_i) valid_q <= 1'b0;
    else         valid_q <= req_i.req;
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : mem_system_pkg::BootromContent[idx];
    end
  end

  always_comb begin
    resp_o        = '0;
    resp_o.rvalid = valid_q;
    resp_o.rdata  = rdata_q;
  end

endmodule : bootrom

/* logic/ctrl_registers.sv */
/*
 * Control registers
 * End of computation flag, wake-up pulse and core count readback
 */

`timescale 1ns/1ps

module ctrl_registers (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  mem_system_pkg::sys_req_t            req_i,
  output mem_system_pkg::sys_resp_t           resp_o,
  output logic                                eoc_valid_o,
  output logic [mem_system_pkg::NumCores-1:0] wake_up_o
);

  logic [mem_system_pkg::CtrlOffWidth-1:0] offset;
  logic                                    wr, rd;
  mem_system_pkg::data_t                   eoc_q;
  logic [mem_system_pkg::NumCores-1:0]     wake_up_q;
  mem_system_pkg::data_t                   rdata, rdata_q;
  logic                                    valid_q;

  assign offset = req_i.addr[mem_system_pkg::CtrlOffWidth-1:0];
  assign wr     = req_i.req && req_i.we;
  assign rd     = req_i.req && !req_i.we;

  // Read decode, wake-up and unknown offsets read zero
  always_comb begin
    rdata = '0;
    if (rd) begin
      unique case (offset)
        mem_system_pkg::EocOffset:      rdata = eoc_q;
        mem_system_pkg::NumCoresOffset: rdata = mem_system_pkg::DataWidth'(mem_system_pkg::NumCores);
        default:                        rdata = '0;
      endcase
    end
  end

  // Whole-word writes, strobes not used here
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      eoc_q <= '0;
    end else if (wr && (offset == mem_system_pkg::EocOffset)) begin
      eoc_q <= req_i.wdata;
    end
  end

  // Wake-up mask lives for exactly one cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wake_up_q <= '0;
    end else if (wr && (offset == mem_system_pkg::WakeUpOffset)) begin
      wake_up_q <= req_i.wdata[mem_system_pkg::NumCores-1:0];
    end else begin
      wake_up_q <= '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) valid_q <= 1'b0;
    else         valid_q <= req_i.req;
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) rdata_q <= rdata; // Zero for writes
  end

  assign eoc_valid_o = eoc_q[0];
  assign wake_up_o   = wake_up_q;

  always_comb begin
    resp_o        = '0;
    resp_o.rvalid = valid_q;
    resp_o.rdata  = rdata_q;
  end

endmodule : ctrl_registers

/* logic/sys_xbar.sv */
/*
 * System crossbar
 * Decodes the host address, steers the strobe and returns the target response
 */

`timescale 1ns/1ps

module sys_xbar (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mem_system_pkg::sys_req_t  host_req_i,
  output mem_system_pkg::sys_resp_t host_resp_o,
  output mem_system_pkg::sys_req_t  l2_req_o,
  input  mem_system_pkg::sys_resp_t l2_resp_i,
  output mem_system_pkg::sys_req_t  rom_req_o,
  input  mem_system_pkg::sys_resp_t rom_resp_i,
  output mem_system_pkg::sys_req_t  ctrl_req_o,
  input  mem_system_pkg::sys_resp_t ctrl_resp_i
);

  mem_system_pkg::target_e tgt, tgt_q;
  logic                    valid_q;

  // Subtracting first keeps the compare free of end-address overflow
  function automatic logic in_range(mem_system_pkg::addr_t addr,
                                    mem_system_pkg::addr_t base,
                                    mem_system_pkg::addr_t size);
    return (addr >= base) && ((addr - base) < size);
  endfunction

  // Address map
  always_comb begin
    if (in_range(host_req_i.addr, mem_system_pkg::L2BaseAddr, mem_system_pkg::L2Size)) begin
      tgt = mem_system_pkg::TgtL2;
    end else if (in_range(host_req_i.addr, mem_system_pkg::BootromBaseAddr,
                          mem_system_pkg::BootromSize)) begin
      tgt = mem_system_pkg::TgtBootrom;
    end else if (in_range(host_req_i.addr, mem_system_pkg::CtrlBaseAddr,
                          mem_system_pkg::CtrlSize)) begin
      tgt = mem_system_pkg::TgtCtrl;
    end else begin
      tgt = mem_system_pkg::TgtNone;
    end
  end

  // Same payload to all targets, strobe only to the selected one
  always_comb begin
    l2_req_o       = host_req_i;
    rom_req_o      = host_req_i;
    ctrl_req_o     = host_req_i;
    l2_req_o.req   = host_req_i.req && (tgt == mem_system_pkg::TgtL2);
    rom_req_o.req  = host_req_i.req && (tgt == mem_system_pkg::TgtBootrom);
    ctrl_req_o.req = host_req_i.req && (tgt == mem_system_pkg::TgtCtrl);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      tgt_q   <= mem_system_pkg::TgtNone;
    end else begin
      valid_q <= host_req_i.req;
      if (host_req_i.req) tgt_q <= tgt; // Remember who answers next cycle
    end
  end

  // Response mux for the request of the previous cycle
  always_comb begin
    host_resp_o = '0;
    if (valid_q) begin
      unique case (tgt_q)
        mem_system_pkg::TgtL2:      host_resp_o = l2_resp_i;
        mem_system_pkg::TgtBootrom: host_resp_o = rom_resp_i;
        mem_system_pkg::TgtCtrl:    host_resp_o = ctrl_resp_i;
        default: begin
          host_resp_o.rvalid = 1'b1; // Unmapped address
          host_resp_o.err    = 1'b1;
        end
      endcase
    end
  end

endmodule : sys_xbar

/* logic/mem_system.sv */
/*
 * Memory subsystem top
 * Host port into the crossbar, which fans out to L2, boot ROM and control registers
 */

`timescale 1ns/1ps

module mem_system (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  mem_system_pkg::sys_req_t         host_req_i,
  output mem_system_pkg::sys_resp_t        host_resp_o,
  output logic                             eoc_valid_o,
  output logic [mem_system_pkg::NumCores-1:0] wake_up_o
);

  mem_system_pkg::sys_req_t  l2_req,   rom_req,   ctrl_req;
  mem_system_pkg::sys_resp_t l2_resp,  rom_resp,  ctrl_resp;

  sys_xbar i_sys_xbar (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .host_req_i (host_req_i ),
    .host_resp_o(host_resp_o),
    .l2_req_o   (l2_req     ),
    .l2_resp_i  (l2_resp    ),
    .rom_req_o  (rom_req    ),
    .rom_resp_i (rom_resp   ),
    .ctrl_req_o (ctrl_req   ),
    .ctrl_resp_i(ctrl_resp  )
  );

  // Interleaved scratch memory
  l2_mem i_l2_mem (
    .clk_i  (clk_i  ),
    .reset_i(reset_i),
    .req_i  (l2_req ),
    .resp_o (l2_resp)
  );

  bootrom i_bootrom (
    .clk_i  (clk_i   ),
    .reset_i(reset_i ),
    .req_i  (rom_req ),
    .resp_o (rom_resp)
  );

  // End of computation and core wake-up
  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .req_i      (ctrl_req   ),
    .resp_o     (ctrl_resp  ),
    .eoc_valid_o(eoc_valid_o),
    .wake_up_o  (wake_up_o  )
  );

endmodule : mem_system

/* tb/mem_system_checker.sv */
/*
 * Crossbar checker
 * Response timing, error flag and one-hot target strobe
 */

`timescale 1ns/1ps

module mem_system_checker (
  input logic                      clk_i,
  input logic                      reset_i,
  input mem_system_pkg::sys_req_t  host_req_i,
  input mem_system_pkg::sys_resp_t host_resp_i,
  input mem_system_pkg::sys_req_t  l2_req_i,
  input mem_system_pkg::sys_req_t  rom_req_i,
  input mem_system_pkg::sys_req_t  ctrl_req_i
);

  int unsigned fail_count = 0; // Failed assertions, summed into the testbench error count

  // A response comes exactly one cycle after each request and never otherwise
  rvalid_after_req: assert property (
    @(posedge clk_i) disable iff (reset_i)
    host_resp_i.rvalid == $past(host_req_i.req)
  ) else begin
    $error("Response valid does not match a request one cycle earlier");
    fail_count++;
  end

  err_with_rvalid: assert property (
    @(posedge clk_i) disable iff (reset_i)
    host_resp_i.err |-> host_resp_i.rvalid
  ) else begin
    $error("Error flag raised without a valid response");
    fail_count++;
  end

  // Never more than one target strobed
  one_target: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $onehot0({l2_req_i.req, rom_req_i.req, ctrl_req_i.req})
  ) else begin
    $error("More than one target request high in the same cycle");
    fail_count++;
  end

endmodule : mem_system_checker

/* tb/mem_system_tb.sv */
/*
 * Memory subsystem testbench
 * Directed table for strobes, ROM, control and unmapped space, then a random L2 pass
 */

`timescale 1ns/1ps

module mem_system_tb;

  typedef struct packed {
    mem_system_pkg::sys_req_t req;
    mem_system_pkg::data_t    rdata;
    logic                     err;
    logic                     eoc;   // eoc_valid_o level once the response is out
  } vec_t;

  typedef struct packed {
    logic                                valid;
    mem_system_pkg::data_t               rdata;
    logic                                err;
    logic                                eoc;
    logic [mem_system_pkg::NumCores-1:0] wake;
  } exp_t;

  logic                                clk;
  logic                                reset;
  mem_system_pkg::sys_req_t            host_req;
  mem_system_pkg::sys_resp_t           host_resp;
  logic                                eoc_valid;
  logic [mem_system_pkg::NumCores-1:0] wake_up;

  vec_t                  vecs[$];
  mem_system_pkg::data_t model [mem_system_pkg::L2Size / 4];
  exp_t                  pending;                // Expected response of the last request
  logic                  eoc_level;
  int unsigned           errors      = 0;
  int unsigned           checks      = 0;
  int unsigned           cycles      = 0;
  int unsigned           cycle_limit = 100000;

  mem_system UUT (
    .clk_i      (clk      ),
    .reset_i    (reset    ),
    .host_req_i (host_req ),
    .host_resp_o(host_resp),
    .eoc_valid_o(eoc_valid),
    .wake_up_o  (wake_up  )
  );

  bind sys_xbar mem_system_checker i_xbar_checker (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .host_req_i (host_req_i ),
    .host_resp_i(host_resp_o),
    .l2_req_i   (l2_req_o   ),
    .rom_req_i  (rom_req_o  ),
    .ctrl_req_i (ctrl_req_o )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the run did not complete", cycles);
      $display("Errors found");
      $finish;
    end
  end

  function automatic mem_system_pkg::sys_req_t make_req(logic req, logic we,
      mem_system_pkg::addr_t addr, mem_system_pkg::data_t wdata, mem_system_pkg::strb_t strb);
    return {req, we, addr, wdata, strb};
  endfunction

  // Wake-up mask follows a write to the wake-up offset
  function automatic exp_t make_exp(mem_system_pkg::sys_req_t r, mem_system_pkg::data_t rdata,
                                    logic err, logic eoc);
    exp_t e;
    e = {r.req, rdata, err, eoc, {mem_system_pkg::NumCores{1'b0}}};
    if (r.req && r.we && (r.addr == mem_system_pkg::CtrlBaseAddr +
                          mem_system_pkg::addr_t'(mem_system_pkg::WakeUpOffset))) begin
      e.wake = r.wdata[mem_system_pkg::NumCores-1:0];
    end
    return e;
  endfunction

  task automatic add_vec(input logic req, input logic we, input mem_system_pkg::addr_t addr,
                         input mem_system_pkg::data_t wdata, input mem_system_pkg::strb_t strb,
                         input mem_system_pkg::data_t rdata, input logic err, input logic eoc);
    vecs.push_back({req, we, addr, wdata, strb, rdata, err, eoc});
  endtask

  task automatic check_resp(input exp_t e);
    checks++;
    assert (host_resp.rvalid === e.valid) else begin
      errors++;
      $display("FAILED host_resp.rvalid got %h expected %h", host_resp.rvalid, e.valid);
    end
    assert (host_resp.err === e.err) else begin
      errors++;
      $display("FAILED host_resp.err got %h expected %h", host_resp.err, e.err);
    end
    if (e.valid) begin
      assert (host_resp.rdata === e.rdata) else begin
        errors++;
        $display("FAILED host_resp.rdata got %h expected %h", host_resp.rdata, e.rdata);
      end
    end
    assert (eoc_valid === e.eoc) else begin
      errors++;
      $display("FAILED eoc_valid_o got %h expected %h", eoc_valid, e.eoc);
    end
    assert (wake_up === e.wake) else begin
      errors++;
      $display("FAILED wake_up_o got %h expected %h", wake_up, e.wake);
    end
  endtask

  // Drive one request, then check the response of the one before
  task automatic step(input mem_system_pkg::sys_req_t r, input exp_t e);
    @(posedge clk);
    host_req <= r;
    @(negedge clk);
    check_resp(pending);
    pending = e;
  endtask

  initial begin
    mem_system_pkg::sys_req_t r;
    mem_system_pkg::data_t    d;
    mem_system_pkg::strb_t    s;
    mem_system_pkg::addr_t    a;
    int unsigned              words;
    int unsigned              rand_ops;

    reset     = 1'b1;
    host_req  = '0;
    pending   = '0;
    eoc_level = 1'b0;
    void'($urandom(86));
    words    = mem_system_pkg::L2Size / 4;
    rand_ops = 4 * words;

    // L2 byte strobes
    add_vec(1'b1, 1'b1, 32'h8000_0010, 32'h1122_3344, 4'hF, 32'h0000_0000, 1'b0, 1'b0);
    add_vec(1'b1, 1'b1, 32'h8000_0010, 32'hAABB_CCDD, 4'h5, 32'h0000_0000, 1'b0, 1'b0);
    add_vec(1'b1, 1'b0, 32'h8000_0010, 32'h0000_0000, 4'h0, 32'h11BB_33DD, 1'b0, 1'b0);
    // Boot ROM reads and a dropped write
    add_vec(1'b1, 1'b0, 32'hA000_0000, 32'h0000_0000, 4'h0, 32'hB007_0000, 1'b0, 1'b0);
    add_vec(1'b1, 1'b0, 32'hA000_0014, 32'h0000_0000, 4'h0, 32'hB007_0005, 1'b0, 1'b0);
    add_vec(1'b1, 1'b0, 32'hA000_001C, 32'h0000_0000, 4'h0, 32'hB007_0007, 1'b0, 1'b0);
    add_vec(1'b1, 1'b1, 32'hA000_0014, 32'hDEAD_BEEF, 4'hF, 32'h0000_0000, 1'b0, 1'b0);
    add_vec(1'b1, 1'b0, 32'hA000_0014, 32'h0000_0000, 4'h0, 32'hB007_0005, 1'b0, 1'b0);
    add_vec(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b0);
    // Control registers
    add_vec(1'b1, 1'b0, 32'h4000_0008, 32'h0000_0000, 4'h0, 32'h0000_0008, 1'b0, 1'b0);
    add_vec(1'b1, 1'b1, 32'h4000_0000, 32'h0000_0005, 4'hF, 32'h0000_0000, 1'b0, 1'b1);
    add_vec(1'b1, 1'b0, 32'h4000_0000, 32'h0000_0000, 4'h0, 32'h0000_0005, 1'b0, 1'b1);
    add_vec(1'b1, 1'b1, 32'h4000_0004, 32'h0000_00A5, 4'hF, 32'h0000_0000, 1'b0, 1'b1);
    add_vec(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b1);
    add_vec(1'b1, 1'b0, 32'h4000_0004, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b1);
    add_vec(1'b1, 1'b0, 32'h4000_000C, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b1);
    add_vec(1'b1, 1'b1, 32'h4000_0008, 32'h0000_0020, 4'hF, 32'h0000_0000, 1'b0, 1'b1);
    add_vec(1'b1, 1'b0, 32'h4000_0008, 32'h0000_0000, 4'h0, 32'h0000_0008, 1'b0, 1'b1);
    // Unmapped space
    add_vec(1'b1, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1, 1'b1);
    add_vec(1'b1, 1'b0, 32'h8000_0400, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1, 1'b1);
    add_vec(1'b1, 1'b1, 32'h0000_0100, 32'h1234_5678, 4'hF, 32'h0000_0000, 1'b1, 1'b1);
    add_vec(1'b1, 1'b1, 32'h4000_0000, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0, 1'b0);
    add_vec(1'b1, 1'b0, 32'h4000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b0);
    add_vec(1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b0);
    cycle_limit = vecs.size() + 2 * rand_ops + 50;

    repeat (8) @(posedge clk);
    reset <= 1'b0;

    foreach (vecs[i]) begin
      eoc_level = vecs[i].eoc;
      step(vecs[i].req, make_exp(vecs[i].req, vecs[i].rdata, vecs[i].err, vecs[i].eoc));
    end

    // Full write, strobed overwrite and immediate read of every L2 word
    for (int w = 0; w < words; w++) begin
      a = mem_system_pkg::L2BaseAddr + mem_system_pkg::addr_t'(w * 4);
      r = make_req(1'b1, 1'b1, a, $urandom, 4'hF);
      model[w] = r.wdata;
      step(r, make_exp(r, '0, 1'b0, eoc_level));
      d = $urandom;
      s = mem_system_pkg::strb_t'($urandom);
      for (int b = 0; b < mem_system_pkg::StrbWidth; b++) begin
        if (s[b]) model[w][b*8 +: 8] = d[b*8 +: 8];
      end
      r = make_req(1'b1, 1'b1, a, d, s);
      step(r, make_exp(r, '0, 1'b0, eoc_level));
      r = make_req(1'b1, 1'b0, a, '0, '0);
      step(r, make_exp(r, model[w], 1'b0, eoc_level));
    end

    for (int w = 0; w < words; w++) begin
      r = make_req(1'b1, 1'b0, mem_system_pkg::L2BaseAddr + mem_system_pkg::addr_t'(w * 4),
                   '0, '0);
      step(r, make_exp(r, model[w], 1'b0, eoc_level));
    end

    r = '0;
    step(r, make_exp(r, '0, 1'b0, eoc_level)); // Drains the last response
    step(r, make_exp(r, '0, 1'b0, eoc_level));

    errors += UUT.i_sys_xbar.i_xbar_checker.fail_count; // Bound crossbar assertions
    $display("Checked %0d cycles, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : mem_system_tb

/* mem_system.f */
logic/mem_system_pkg.sv
logic/l2_bank.sv
logic/l2_mem.sv
logic/bootrom.sv
logic/ctrl_registers.sv
logic/sys_xbar.sv
logic/mem_system.sv
tb/mem_system_checker.sv
tb/mem_system_tb.sv
